// File: hw/cpu_pkg.sv
package cpu_pkg;

    // Widths that carry a meaning across the core
    typedef logic [31:0] word_t;         // Data word or byte address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  rom_addr_t;     // Instruction word index on the ROM port
    typedef logic [5:0]  led_t;
    typedef logic [7:0]  duty_t;         // PWM duty and PWM counter

    // RV32I major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;   // ADD SUB AND OR XOR SLT
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;   // ADDI
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;   // LW
    localparam logic [6:0] OPC_STORE  = 7'b0100011;   // SW
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;   // BEQ BNE
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // Peripheral space is every address with this bit set
    localparam int PERIPH_BIT = 31;

    // Byte offsets of the peripheral registers
    localparam logic [7:0] LED_OFFSET  = 8'h00;
    localparam logic [7:0] DUTY_OFFSET = 8'h04;
    localparam logic [7:0] BTN_OFFSET  = 8'h08;   // Read only

endpackage

// File: hw/ex_mem_if.sv
interface ex_mem_if;
    // Execute/memory pipeline register
    logic               valid;
    cpu_pkg::word_t     result;       // ALU result, memory address or link address
    cpu_pkg::word_t     store_data;
    cpu_pkg::reg_addr_t rd;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;

    // Write-back, also the forwarding source for execute
    logic               wb_en;
    cpu_pkg::reg_addr_t wb_rd;
    cpu_pkg::word_t     wb_data;
    logic               stall;        // APB setup cycle

    modport execute (
        output valid, result, store_data, rd, reg_write, mem_read, mem_write,
        input  wb_en, wb_rd, wb_data, stall
    );

    modport memory (
        input  valid, result, store_data, rd, reg_write, mem_read, mem_write,
        output wb_en, wb_rd, wb_data, stall
    );
endinterface

// File: hw/apb_if.sv
interface apb_if;
    logic           psel;
    logic           penable;
    logic           pwrite;
    cpu_pkg::word_t paddr;
    cpu_pkg::word_t pwdata;
    cpu_pkg::word_t prdata;
    logic           pready;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );
endinterface

// File: hw/fetch.sv
module fetch #(
    parameter cpu_pkg::word_t RESET_PC = '0     // Byte address of the first instruction
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               hold,
    input  logic               redirect,
    input  cpu_pkg::word_t     target,
    input  cpu_pkg::word_t     rom_data,
    output cpu_pkg::rom_addr_t rom_address,
    output cpu_pkg::word_t     instr,
    output cpu_pkg::word_t     pc,
    output logic               instr_valid
);
    cpu_pkg::word_t pc_q;

    // Word index of the current PC
    assign rom_address = pc_q[$bits(cpu_pkg::rom_addr_t)+1:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q        <= RESET_PC;
            instr_valid <= 1'b0;
        end else if (!hold) begin
            if (redirect) begin
                pc_q        <= target;
                instr_valid <= 1'b0;     // Squash the word fetched behind the branch
            end else begin
                pc_q        <= pc_q + 32'd4;
                instr_valid <= 1'b1;
            end
        end
    end

    // Fetch/execute register payload
    always_ff @(posedge clock) begin
        if (!hold) begin
            instr <= rom_data;
            pc    <= pc_q;
        end
    end
endmodule

// File: hw/register_bank.sv
module register_bank (
    input  logic               clock,
    input  logic               reset,
    input  logic               write_enable,
    input  cpu_pkg::reg_addr_t write_address,
    input  cpu_pkg::word_t     write_value,
    input  cpu_pkg::reg_addr_t read_address1,
    input  cpu_pkg::reg_addr_t read_address2,
    output cpu_pkg::word_t     value1,
    output cpu_pkg::word_t     value2
);
    cpu_pkg::word_t regs [1:31];     // x0 has no storage

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_address != '0) begin
            regs[write_address] <= write_value;
        end
    end

    // Asynchronous reads, x0 reads as zero
    assign value1 = (read_address1 == '0) ? '0 : regs[read_address1];
    assign value2 = (read_address2 == '0) ? '0 : regs[read_address2];
endmodule

// File: hw/decode_execute.sv
module decode_execute (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::word_t     instr,
    input  cpu_pkg::word_t     pc,
    input  logic               instr_valid,
    input  cpu_pkg::word_t     value1,
    input  cpu_pkg::word_t     value2,
    output cpu_pkg::reg_addr_t read_address1,
    output cpu_pkg::reg_addr_t read_address2,
    output logic               redirect,
    output cpu_pkg::word_t     target,
    ex_mem_if.execute          em
);
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;    // LW and SW
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     imm_i, imm_s, imm_b, imm_j;
    cpu_pkg::word_t     op_a, op_b, alu_b, sum, result;
    logic               reg_write, mem_read, mem_write, take;

    assign opcode        = instr[6:0];
    assign rd            = instr[11:7];
    assign funct3        = instr[14:12];
    assign read_address1 = instr[19:15];
    assign read_address2 = instr[24:20];
    assign funct7        = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // The instruction in memory/writeback is the only one not yet in the bank
    assign op_a = (em.wb_en && em.wb_rd == read_address1) ? em.wb_data : value1;
    assign op_b = (em.wb_en && em.wb_rd == read_address2) ? em.wb_data : value2;

    assign alu_b = (opcode == cpu_pkg::OPC_OP)    ? op_b :
                   (opcode == cpu_pkg::OPC_STORE) ? imm_s : imm_i;
    assign sum   = op_a + alu_b;

    always_comb begin
        result    = sum;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        take      = 1'b0;
        case (opcode)
            cpu_pkg::OPC_OP: begin
                // Only funct7 0, or 0x20 for SUB
                if (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == F3_ADD)) begin
                    reg_write = 1'b1;
                    case (funct3)
                        F3_ADD:  result = funct7[5] ? op_a - op_b : sum;
                        F3_SLT:  result = {31'b0, $signed(op_a) < $signed(op_b)};
                        F3_XOR:  result = op_a ^ op_b;
                        F3_OR:   result = op_a | op_b;
                        F3_AND:  result = op_a & op_b;
                        default: reg_write = 1'b0;
                    endcase
                end
            end
            cpu_pkg::OPC_OP_IMM: reg_write = (funct3 == F3_ADD);
            cpu_pkg::OPC_LOAD: begin
                reg_write = (funct3 == F3_WORD);
                mem_read  = (funct3 == F3_WORD);
            end
            cpu_pkg::OPC_STORE: mem_write = (funct3 == F3_WORD);
            cpu_pkg::OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  take = (op_a == op_b);
                    F3_BNE:  take = (op_a != op_b);
                    default: take = 1'b0;
                endcase
            end
            cpu_pkg::OPC_JAL: begin
                reg_write = 1'b1;
                take      = 1'b1;
                result    = pc + 32'd4;      // Link address
            end
            default: ;                       // Anything else runs as a no-op
        endcase
    end

    assign target   = pc + ((opcode == cpu_pkg::OPC_JAL) ? imm_j : imm_b);
    assign redirect = instr_valid & take;

    // Execute/memory register, control part
    always_ff @(posedge clock) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
        end else if (enable && !em.stall) begin
            em.valid     <= instr_valid;
            em.reg_write <= instr_valid && reg_write && rd != '0;   // x0 never written
            em.mem_read  <= instr_valid && mem_read;
            em.mem_write <= instr_valid && mem_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable && !em.stall) begin
            em.result     <= result;
            em.store_data <= op_b;
            em.rd         <= rd;
        end
    end
endmodule

// File: hw/memory_stage.sv
module memory_stage #(
    parameter int RAM_WORDS = 256
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      enable,
    ex_mem_if.memory  em,
    apb_if.master     apb
);
    localparam int INDEX_BITS = $clog2(RAM_WORDS);

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    apb_state_t            state_q;
    apb_state_t            phase;          // Phase of the current cycle
    cpu_pkg::word_t        ram [RAM_WORDS];
    cpu_pkg::word_t        ram_rdata;
    logic [INDEX_BITS-1:0] ram_index;
    logic                  mem_access, periph, ram_access, access_done;

    assign mem_access = em.valid & (em.mem_read | em.mem_write);
    assign periph     = mem_access & em.result[cpu_pkg::PERIPH_BIT];
    assign ram_access = mem_access & ~em.result[cpu_pkg::PERIPH_BIT];
    assign ram_index  = em.result[INDEX_BITS+1:2];
    assign ram_rdata  = ram[ram_index];

    always_ff @(posedge clock) begin
        if (enable && ram_access && em.mem_write) begin
            ram[ram_index] <= em.store_data;
        end
    end

    // Setup is the first cycle a peripheral access sits in this stage
    always_comb begin
        if (state_q == APB_ACCESS) begin
            phase = APB_ACCESS;
        end else if (periph && enable) begin
            phase = APB_SETUP;               // No new transfer while enable is low
        end else begin
            phase = APB_IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= APB_IDLE;
        end else if (enable) begin
            if (phase == APB_SETUP) begin
                state_q <= APB_ACCESS;
            end else if (phase == APB_ACCESS && apb.pready) begin
                state_q <= APB_IDLE;
            end
        end
    end

    // Address and data come straight from the held pipeline register
    assign apb.psel    = (phase != APB_IDLE);
    assign apb.penable = (phase == APB_ACCESS);
    assign apb.pwrite  = em.mem_write;
    assign apb.paddr   = em.result;
    assign apb.pwdata  = em.store_data;

    assign access_done = !periph || (phase == APB_ACCESS && apb.pready);
    assign em.stall    = (phase == APB_SETUP) || (phase == APB_ACCESS && !apb.pready);

    assign em.wb_en   = enable & em.valid & em.reg_write & access_done;
    assign em.wb_rd   = em.rd;
    assign em.wb_data = !em.mem_read                   ? em.result :
                        em.result[cpu_pkg::PERIPH_BIT] ? apb.prdata : ram_rdata;
endmodule

// File: hw/peripheral_manager.sv
module peripheral_manager (
    input  logic          clock,
    input  logic          reset,
    input  logic          btn1,
    input  logic          btn2,
    output cpu_pkg::led_t led,
    output logic          port_pwm1,
    apb_if.slave          apb
);
    cpu_pkg::led_t  led_q;
    cpu_pkg::duty_t duty_q;
    cpu_pkg::duty_t pwm_count;
    logic [1:0]     btn_meta, btn_sync;    // {btn2, btn1}
    logic [7:0]     offset;
    logic           write_strobe;

    assign offset       = apb.paddr[7:0];
    assign write_strobe = apb.psel & apb.penable & apb.pwrite;
    assign apb.pready   = 1'b1;              // Zero wait states

    always_ff @(posedge clock) begin
        if (reset) begin
            led_q  <= '0;
            duty_q <= '0;
        end else if (write_strobe) begin
            if (offset == cpu_pkg::LED_OFFSET) led_q <= apb.pwdata[5:0];
            if (offset == cpu_pkg::DUTY_OFFSET) duty_q <= apb.pwdata[7:0];
        end
    end

    // Buttons are asynchronous
    always_ff @(posedge clock) begin
        if (reset) begin
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            btn_meta <= {btn2, btn1};
            btn_sync <= btn_meta;
        end
    end

    always_comb begin
        case (offset)
            cpu_pkg::LED_OFFSET:  apb.prdata = cpu_pkg::word_t'(led_q);
            cpu_pkg::DUTY_OFFSET: apb.prdata = cpu_pkg::word_t'(duty_q);
            cpu_pkg::BTN_OFFSET:  apb.prdata = cpu_pkg::word_t'(btn_sync);
            default:              apb.prdata = '0;
        endcase
    end

    // Free-running PWM, high for duty counts out of 256
    always_ff @(posedge clock) begin
        if (reset) begin
            pwm_count <= '0;
            port_pwm1 <= 1'b0;
        end else begin
            pwm_count <= pwm_count + 8'd1;
            port_pwm1 <= (pwm_count < duty_q);
        end
    end

    assign led = ~led_q;     // LEDs are active low
endmodule

// File: hw/cpu.sv
module cpu #(
    parameter int             RAM_WORDS = 256,
    parameter cpu_pkg::word_t RESET_PC  = '0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               enable,
    input  cpu_pkg::word_t     rom_data,
    output cpu_pkg::rom_addr_t rom_address,
    input  logic               btn1,
    input  logic               btn2,
    output cpu_pkg::led_t      led,
    output logic               port_pwm1
);
    cpu_pkg::word_t     instr, pc, target;
    cpu_pkg::word_t     rb_value1, rb_value2;
    cpu_pkg::reg_addr_t rb_read_address1, rb_read_address2;
    logic               instr_valid, redirect, fetch_hold;

    ex_mem_if em ();
    apb_if    apb ();

    assign fetch_hold = em.stall | ~enable;

    fetch #(.RESET_PC(RESET_PC)) i_fetch (
        .clock(clock), .reset(reset), .hold(fetch_hold),
        .redirect(redirect), .target(target),
        .rom_data(rom_data), .rom_address(rom_address),
        .instr(instr), .pc(pc), .instr_valid(instr_valid)
    );

    // Written from the memory/writeback stage
    register_bank i_register_bank (
        .clock(clock), .reset(reset),
        .write_enable(em.wb_en), .write_address(em.wb_rd), .write_value(em.wb_data),
        .read_address1(rb_read_address1), .read_address2(rb_read_address2),
        .value1(rb_value1), .value2(rb_value2)
    );

    decode_execute i_decode_execute (
        .clock(clock), .reset(reset), .enable(enable),
        .instr(instr), .pc(pc), .instr_valid(instr_valid),
        .value1(rb_value1), .value2(rb_value2),
        .read_address1(rb_read_address1), .read_address2(rb_read_address2),
        .redirect(redirect), .target(target),
        .em(em.execute)
    );

    memory_stage #(.RAM_WORDS(RAM_WORDS)) i_memory_stage (
        .clock(clock), .reset(reset), .enable(enable),
        .em(em.memory),
        .apb(apb.master)
    );

    peripheral_manager i_peripheral_manager (
        .clock(clock), .reset(reset),
        .btn1(btn1), .btn2(btn2),
        .led(led), .port_pwm1(port_pwm1),
        .apb(apb.slave)
    );
endmodule

// File: bench/cpu_asserts.sv
module cpu_asserts (
    input logic               clock,
    input logic               reset,
    input logic               psel,
    input logic               penable,
    input cpu_pkg::word_t     paddr,
    input logic               write_enable,
    input cpu_pkg::reg_addr_t write_address,
    input logic               stall
);
    penable_with_psel: assert property (@(posedge clock) disable iff (reset) penable |-> psel)
        else $error("penable high without psel");

    // Setup is always followed by access with the same address
    paddr_stable: assert property (@(posedge clock) disable iff (reset)
        psel && !penable |=> penable && $stable(paddr))
        else $error("paddr changed between setup and access");

    no_x0_write: assert property (@(posedge clock) disable iff (reset)
        write_enable |-> write_address != 5'd0)
        else $error("register bank write enabled for x0");

    single_stall: assert property (@(posedge clock) disable iff (reset) stall |=> !stall)
        else $error("stall held for more than one cycle");    // Zero wait state slave
endmodule

bind cpu cpu_asserts i_asserts (
    .clock(clock), .reset(reset),
    .psel(apb.psel), .penable(apb.penable), .paddr(apb.paddr),
    .write_enable(em.wb_en), .write_address(em.wb_rd),
    .stall(em.stall)
);

// File: bench/cpu_tb.sv
module cpu_tb;
    localparam int MAX_CYCLES = 3000;    // The program with its enable gap and PWM window needs under 500 cycles

    logic               clock;
    logic               reset;
    logic               enable;
    logic               btn1;
    logic               btn2;
    cpu_pkg::word_t     rom_data;
    cpu_pkg::rom_addr_t rom_address;
    cpu_pkg::led_t      led;
    logic               port_pwm1;

    cpu_pkg::word_t rom [256];
    int             prog_len = 0;
    cpu_pkg::led_t  exp_leds[$];        // LED register values in order of change
    cpu_pkg::duty_t exp_duty;
    cpu_pkg::led_t  last_led = '1;
    int             seen = 0;
    int             mismatches = 0;
    int             failures = 0;
    int             seed;

    cpu #(.RAM_WORDS(256), .RESET_PC('0)) i_dut (
        .clock(clock), .reset(reset), .enable(enable),
        .rom_data(rom_data), .rom_address(rom_address),
        .btn1(btn1), .btn2(btn2), .led(led), .port_pwm1(port_pwm1)
    );

    assign rom_data = rom[rom_address];    // Combinational instruction ROM

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Small RV32I encoders
    function automatic cpu_pkg::word_t op_r(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), cpu_pkg::OPC_OP};
    endfunction

    function automatic cpu_pkg::word_t op_i(input logic [6:0] opc, input int rd,
                                            input int rs1, input int imm);
        logic [2:0] f3 = (opc == cpu_pkg::OPC_LOAD) ? 3'b010 : 3'b000;
        return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic cpu_pkg::word_t op_s(input int rs2, input int rs1, input int imm);
        logic [11:0] i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], cpu_pkg::OPC_STORE};
    endfunction

    function automatic cpu_pkg::word_t op_b(input int f3, input int rs1, input int rs2,
                                            input int off);
        logic [12:0] o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], cpu_pkg::OPC_BRANCH};
    endfunction

    function automatic cpu_pkg::word_t op_j(input int rd, input int off);
        logic [20:0] o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), cpu_pkg::OPC_JAL};
    endfunction

    task automatic emit(input cpu_pkg::word_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program();
        for (int i = 0; i < 256; i++) begin
            rom[i] = op_i(cpu_pkg::OPC_OP_IMM, 0, 0, i);    // No-ops tagged with their address
        end
        emit(op_i(cpu_pkg::OPC_OP_IMM, 10, 0, -2048));      // Peripheral base 0xfffff800 in x10
        emit(op_i(cpu_pkg::OPC_OP_IMM, 1, 0, 5));
        emit(op_i(cpu_pkg::OPC_OP_IMM, 2, 1, 7));
        emit(op_r(0, 0, 3, 1, 2));                          // ADD
        emit(op_r(32, 0, 4, 3, 1));                         // SUB
        emit(op_r(0, 6, 5, 3, 2));                          // OR
        emit(op_r(0, 7, 6, 3, 5));                          // AND
        emit(op_r(0, 4, 7, 5, 6));                          // XOR
        emit(op_i(cpu_pkg::OPC_OP_IMM, 9, 0, -3));
        emit(op_r(0, 2, 8, 9, 4));                          // SLT with a negative operand
        emit(op_r(0, 0, 8, 8, 7));
        emit(op_s(3, 10, 0));
        emit(op_s(8, 10, 0));
        // RAM store, dependent load, load-use
        emit(op_s(7, 0, 16));
        emit(op_i(cpu_pkg::OPC_LOAD, 11, 0, 16));
        emit(op_i(cpu_pkg::OPC_OP_IMM, 11, 11, 9));
        emit(op_s(11, 10, 0));
        // Countdown loop at word 18
        emit(op_i(cpu_pkg::OPC_OP_IMM, 12, 0, 4));
        emit(op_s(12, 10, 0));
        emit(op_i(cpu_pkg::OPC_OP_IMM, 12, 12, -1));
        emit(op_b(1, 12, 0, -8));                           // BNE back to word 18
        emit(op_i(cpu_pkg::OPC_OP_IMM, 12, 12, 40));        // Squashed while the loop is taken
        emit(op_j(14, 12));                                 // JAL over the next two
        emit(op_s(12, 10, 0));
        emit(op_i(cpu_pkg::OPC_OP_IMM, 12, 0, 1));
        emit(op_s(14, 10, 0));                              // Link address to the LEDs
        emit(op_i(cpu_pkg::OPC_LOAD, 15, 10, 8));           // Buttons
        emit(op_s(15, 10, 0));
        emit(op_i(cpu_pkg::OPC_OP_IMM, 16, 0, 100));
        emit(op_s(16, 10, 4));                              // PWM duty
        emit(op_i(cpu_pkg::OPC_OP_IMM, 17, 0, 42));
        emit(op_s(17, 10, 0));
        emit(op_j(0, 0));                                   // Halt loop
    endtask

    // Sequential ISA model of the program in rom
    function automatic cpu_pkg::duty_t ref_run(input logic b1, input logic b2,
                                               output cpu_pkg::led_t leds[$]);
        cpu_pkg::word_t regs [32];
        cpu_pkg::word_t ram [256];
        cpu_pkg::word_t pc, ins, a, b, res, addr, next_pc, imm_i, imm_s, imm_b, imm_j;
        logic           wr;
        cpu_pkg::led_t  led_reg;
        cpu_pkg::duty_t duty;
        regs = '{default: '0};
        ram = '{default: '0};
        leds.delete();
        pc = '0;
        led_reg = '0;
        duty = '0;
        for (int steps = 0; steps < 1000; steps++) begin
            ins = rom[pc[9:2]];
            if (ins == op_j(0, 0)) break;
            a = regs[ins[19:15]];
            b = regs[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            addr = a + ((ins[6:0] == cpu_pkg::OPC_STORE) ? imm_s : imm_i);
            next_pc = pc + 4;
            wr = 1'b1;
            res = '0;
            case (ins[6:0])
                cpu_pkg::OPC_OP: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: res = a + b;
                        4'b1000: res = a - b;
                        4'b0010: res = cpu_pkg::word_t'($signed(a) < $signed(b));
                        4'b0100: res = a ^ b;
                        4'b0110: res = a | b;
                        4'b0111: res = a & b;
                        default: wr = 1'b0;
                    endcase
                end
                cpu_pkg::OPC_OP_IMM: res = addr;            // ADDI only
                cpu_pkg::OPC_LOAD: begin
                    if (!addr[cpu_pkg::PERIPH_BIT]) res = ram[addr[9:2]];
                    else if (addr[7:0] == cpu_pkg::BTN_OFFSET) res = {30'b0, b2, b1};
                    else if (addr[7:0] == cpu_pkg::LED_OFFSET) res = 32'(led_reg);
                    else if (addr[7:0] == cpu_pkg::DUTY_OFFSET) res = 32'(duty);
                end
                cpu_pkg::OPC_STORE: begin
                    wr = 1'b0;
                    if (!addr[cpu_pkg::PERIPH_BIT]) begin
                        ram[addr[9:2]] = b;
                    end else if (addr[7:0] == cpu_pkg::DUTY_OFFSET) begin
                        duty = b[7:0];
                    end else if (addr[7:0] == cpu_pkg::LED_OFFSET && b[5:0] != led_reg) begin
                        led_reg = b[5:0];
                        leds.push_back(led_reg);            // Only changes show on led
                    end
                end
                cpu_pkg::OPC_BRANCH: begin
                    wr = 1'b0;
                    // BEQ has funct3 bit 0 clear, BNE set
                    if ((ins[12] == 1'b0) == (a == b)) next_pc = pc + imm_b;
                end
                cpu_pkg::OPC_JAL: begin
                    res = pc + 4;
                    next_pc = pc + imm_j;
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) regs[ins[11:7]] = res;
            pc = next_pc;
        end
        return duty;
    endfunction

    task automatic check_led(input cpu_pkg::led_t actual, input cpu_pkg::led_t expected,
                             input string what);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_duty(input cpu_pkg::duty_t actual, input cpu_pkg::duty_t expected,
                              input string what);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
        end
    endtask

    task automatic finish_run();
        $display("LED changes %0d of %0d, %0d mismatches, %0d other errors",
                 seen, exp_leds.size(), mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // Compare each LED change against the model as it happens
    always @(negedge clock) begin
        if (!reset && led !== last_led) begin
            if (seen < exp_leds.size()) begin
                check_led(~led, exp_leds[seen], "LED write");
            end else begin
                failures++;
                $display("extra LED write of %h after the expected sequence", ~led);
            end
            seen++;
            last_led = led;
        end
    end

    initial begin
        cpu_pkg::led_t frozen;
        int            high_count;
        seed = 97;
        reset = 1'b1;
        enable = 1'b1;
        {btn2, btn1} = 2'($random(seed));
        load_program();
        exp_duty = ref_run(btn1, btn2, exp_leds);
        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        repeat (6) begin
            @(negedge clock);
            check_led(led, '1, "led after reset");
            if (port_pwm1 !== 1'b0) begin
                failures++;
                $display("port_pwm1 was not low before any duty write");
            end
        end
        repeat (14) @(posedge clock);
        #1 enable = 1'b0;
        // An APB access already in flight completes at the first edge
        @(negedge clock);
        frozen = led;
        repeat (19) begin
            @(negedge clock);
            check_led(led, frozen, "led while enable low");
        end
        @(posedge clock);
        #1 enable = 1'b1;
        wait (seen == exp_leds.size());
        repeat (10) @(negedge clock);
        high_count = 0;
        repeat (256) begin
            @(negedge clock);
            if (port_pwm1) high_count++;
        end
        check_duty(8'(high_count), exp_duty, "port_pwm1 high count");
        finish_run();
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        failures++;
        $display("timeout after %0d cycles with %0d of %0d LED changes seen",
                 cycles, seen, exp_leds.size());
        finish_run();
    end
endmodule

// File: cpu.f
hw/cpu_pkg.sv
hw/ex_mem_if.sv
hw/apb_if.sv
hw/fetch.sv
hw/register_bank.sv
hw/decode_execute.sv
hw/memory_stage.sv
hw/peripheral_manager.sv
hw/cpu.sv
bench/cpu_asserts.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f

status=0
./obj_dir/Vcpu_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF -- '*** TEST FAILED ***' sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
